//--- verilog/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// data widths
`define CACHE_WORD_W        32
`define CACHE_LINE_W        128     // one line is also one memory beat

// address split
`define CACHE_ADDR_W        30      // processor word address
`define CACHE_BLOCK_ADDR_W  28      // memory line address
`define CACHE_TAG_W         26
`define CACHE_INDEX_W       2
`define CACHE_OFFSET_W      2       // word within a line

// geometry
`define CACHE_SETS          4
`define CACHE_WAYS          2

`endif

//--- verilog/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

    // one processor address, seen as a lookup key or as a memory line address
    typedef union packed {
        struct packed {
            logic [`CACHE_TAG_W-1:0]    tag;
            logic [`CACHE_INDEX_W-1:0]  index;
            logic [`CACHE_OFFSET_W-1:0] offset;     // lowest bits
        } fields;
        struct packed {
            logic [`CACHE_BLOCK_ADDR_W-1:0] block_addr;
            logic [`CACHE_OFFSET_W-1:0]     offset;
        } block;
    } proc_addr_u;

endpackage

//--- verilog/line_datapath.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module line_datapath (
    input  logic [`CACHE_LINE_W-1:0]   hit_line,
    input  logic [`CACHE_LINE_W-1:0]   mem_rdata,
    input  logic                       use_mem,
    input  logic [`CACHE_OFFSET_W-1:0] offset,
    input  logic [`CACHE_WORD_W-1:0]   proc_wdata,
    input  logic                       merge,
    output logic [`CACHE_WORD_W-1:0]   word_rdata,
    output logic [`CACHE_LINE_W-1:0]   merged_line
);

    logic [`CACHE_LINE_W-1:0] src_line;

    // refill data bypasses the array
    assign src_line = use_mem ? mem_rdata : hit_line;

    // word k sits at bits 32k upward
    assign word_rdata = src_line[offset*`CACHE_WORD_W +: `CACHE_WORD_W];

    always_comb begin
        merged_line = src_line;
        if (merge) begin
            merged_line[offset*`CACHE_WORD_W +: `CACHE_WORD_W] = proc_wdata;
        end
    end

endmodule

//--- verilog/replace_policy.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module replace_policy (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  logic [`CACHE_INDEX_W-1:0]  index,
    input  logic [`CACHE_WAYS-1:0]     set_valid,
    input  logic                       touch,
    input  logic                       touch_way,
    output logic                       victim_way
);

    logic mru_q [`CACHE_SETS];      // way used last in each set

    always_comb begin
        if (!set_valid[0]) begin
            victim_way = 1'b0;                      // fill way 0 first
        end else if (!set_valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = !mru_q[index];             // evict the older way
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                mru_q[s] <= 1'b0;
            end
        end else if (touch) begin
            mru_q[index] <= touch_way;
        end
    end

endmodule

//--- verilog/way_array.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module way_array
    import cache_pkg::*;
(
    input  logic                       clk,
    input  logic                       proc_reset,
    input  proc_addr_u                 addr,
    input  logic                       line_we,
    input  logic                       line_way,
    input  logic [`CACHE_LINE_W-1:0]   line_wdata,
    output logic                       hit,
    output logic                       hit_way,
    output logic [`CACHE_LINE_W-1:0]   hit_line,
    output logic [`CACHE_WAYS-1:0]     set_valid
);

    logic [`CACHE_WAYS-1:0]     valid_q [`CACHE_SETS];
    logic [`CACHE_TAG_W-1:0]    tag_q   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_LINE_W-1:0]   line_q  [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]     way_hit;

    assign set_valid = valid_q[addr.fields.index];

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = set_valid[w] && (tag_q[addr.fields.index][w] == addr.fields.tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];                       // way 0 unless way 1 matched
    assign hit_line = line_q[addr.fields.index][hit_way];

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (line_we) begin
            valid_q[addr.fields.index][line_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_q[addr.fields.index][line_way]  <= addr.fields.tag;
            line_q[addr.fields.index][line_way] <= line_wdata;
        end
    end

    // refills only go to a missing line, so a tag lives in one way at most
    a_single_hit: assert property (@(posedge clk) disable iff (proc_reset)
        !(way_hit[0] && way_hit[1]));

endmodule

//--- verilog/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                           clk,
    input  logic                           proc_reset,
    input  logic                           proc_read,
    input  logic                           proc_write,
    input  proc_addr_u                     proc_addr,
    output logic                           proc_stall,
    output logic                           mem_read,
    output logic                           mem_write,
    output logic [`CACHE_BLOCK_ADDR_W-1:0] mem_addr,
    output logic [`CACHE_LINE_W-1:0]       mem_wdata,
    input  logic                           mem_ready,
    input  logic                           hit,
    input  logic                           hit_way,
    input  logic                           victim_way,
    input  logic [`CACHE_LINE_W-1:0]       merged_line,
    output logic                           line_we,
    output logic                           line_way,
    output logic                           use_mem,
    output logic                           merge,
    output logic                           touch,
    output logic                           touch_way
);

    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_read_wait  = 2'd1;  // refill for a read
    localparam logic [1:0] st_alloc_wait = 2'd2;  // refill for a write miss
    localparam logic [1:0] st_write_wait = 2'd3;  // write-through in flight

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       sel_way;

    // a hit updates the way it hit, a refill goes to the victim
    assign sel_way   = (state == st_idle) ? hit_way : victim_way;
    assign line_way  = sel_way;
    assign touch_way = sel_way;

    always_comb begin
        state_nxt  = state;
        proc_stall = 1'b0;
        use_mem    = 1'b0;
        merge      = 1'b0;
        line_we    = 1'b0;
        touch      = 1'b0;
        case (state)
            st_idle: begin
                if (proc_read) begin
                    if (hit) begin
                        touch = 1'b1;                   // read hit, no stall
                    end else begin
                        proc_stall = 1'b1;
                        state_nxt  = st_read_wait;
                    end
                end else if (proc_write) begin
                    proc_stall = 1'b1;
                    merge      = 1'b1;
                    if (hit) begin
                        line_we   = 1'b1;               // merge word into hit line
                        touch     = 1'b1;
                        state_nxt = st_write_wait;
                    end else begin
                        state_nxt = st_alloc_wait;
                    end
                end
            end
            st_read_wait: begin
                use_mem    = 1'b1;
                proc_stall = !mem_ready;                // data goes out with mem_ready
                if (mem_ready) begin
                    line_we   = 1'b1;
                    touch     = 1'b1;
                    state_nxt = st_idle;
                end
            end
            st_alloc_wait: begin
                use_mem    = 1'b1;
                merge      = 1'b1;                      // refill line plus new word
                proc_stall = 1'b1;
                if (mem_ready) begin
                    line_we   = 1'b1;
                    touch     = 1'b1;
                    state_nxt = st_write_wait;
                end
            end
            default: begin
                proc_stall = !mem_ready;
                if (mem_ready) begin
                    state_nxt = st_idle;
                end
            end
        endcase
    end

    // memory strobes follow the state we are entering
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state     <= st_idle;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state     <= state_nxt;
            mem_read  <= (state_nxt == st_read_wait) || (state_nxt == st_alloc_wait);
            mem_write <= (state_nxt == st_write_wait);
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && state_nxt != st_idle) begin
            mem_addr <= proc_addr.block.block_addr;     // held after the transfer
        end
        if (line_we) begin
            mem_wdata <= merged_line;                   // whole line goes through
        end
    end

    a_one_request: assert property (@(posedge clk) disable iff (proc_reset)
        !(proc_read && proc_write));

    // a pending memory request keeps its strobe, address and line until mem_ready
    a_mem_hold: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready
        |=> $stable({mem_read, mem_write, mem_addr, mem_wdata}));

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic                           clk,
    input  logic                           proc_reset,
    input  logic                           proc_read,
    input  logic                           proc_write,
    input  proc_addr_u                     proc_addr,
    input  logic [`CACHE_WORD_W-1:0]       proc_wdata,
    output logic                           proc_stall,
    output logic [`CACHE_WORD_W-1:0]       proc_rdata,
    output logic                           mem_read,
    output logic                           mem_write,
    output logic [`CACHE_BLOCK_ADDR_W-1:0] mem_addr,
    output logic [`CACHE_LINE_W-1:0]       mem_wdata,
    input  logic [`CACHE_LINE_W-1:0]       mem_rdata,
    input  logic                           mem_ready
);

    logic                       hit;
    logic                       hit_way;
    logic [`CACHE_LINE_W-1:0]   hit_line;
    logic [`CACHE_WAYS-1:0]     set_valid;
    logic                       victim_way;
    logic                       line_we;
    logic                       line_way;
    logic                       use_mem;
    logic                       merge;
    logic                       touch;
    logic                       touch_way;
    logic [`CACHE_LINE_W-1:0]   merged_line;
    logic [`CACHE_WORD_W-1:0]   word_rdata;

    cache_ctrl i_ctrl (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .proc_read   (proc_read),
        .proc_write  (proc_write),
        .proc_addr   (proc_addr),
        .proc_stall  (proc_stall),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .merged_line (merged_line),
        .line_we     (line_we),
        .line_way    (line_way),
        .use_mem     (use_mem),
        .merge       (merge),
        .touch       (touch),
        .touch_way   (touch_way)
    );

    way_array i_ways (
        .clk        (clk),
        .proc_reset (proc_reset),
        .addr       (proc_addr),
        .line_we    (line_we),
        .line_way   (line_way),
        .line_wdata (merged_line),      // refill or merged write line
        .hit        (hit),
        .hit_way    (hit_way),
        .hit_line   (hit_line),
        .set_valid  (set_valid)
    );

    replace_policy i_repl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (proc_addr.fields.index),
        .set_valid  (set_valid),
        .touch      (touch),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    line_datapath i_dp (
        .hit_line    (hit_line),
        .mem_rdata   (mem_rdata),
        .use_mem     (use_mem),
        .offset      (proc_addr.fields.offset),
        .proc_wdata  (proc_wdata),
        .merge       (merge),
        .word_rdata  (word_rdata),
        .merged_line (merged_line)
    );

    assign proc_rdata = word_rdata;     // valid only when a read completes

endmodule

//--- verification/mem_model.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module mem_model (
    input  logic                           clk,
    input  logic                           proc_reset,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic [`CACHE_BLOCK_ADDR_W-1:0] mem_addr,
    input  logic [`CACHE_LINE_W-1:0]       mem_wdata,
    output logic [`CACHE_LINE_W-1:0]       mem_rdata,
    output logic                           mem_ready
);

    logic [`CACHE_WORD_W-1:0] words [logic [`CACHE_ADDR_W-1:0]];  // only written words
    logic                     busy;
    int unsigned              wait_cnt;

    // untouched words follow the fill rule over the whole word address
    function automatic logic [`CACHE_WORD_W-1:0] word_at(input logic [`CACHE_ADDR_W-1:0] w);
        if (words.exists(w)) begin
            return words[w];
        end
        return ({2'b00, w} * 32'd3) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [`CACHE_LINE_W-1:0] read_line(
        input logic [`CACHE_BLOCK_ADDR_W-1:0] b
    );
        logic [`CACHE_LINE_W-1:0] line;
        for (int k = 0; k < 4; k++) begin
            line[k*`CACHE_WORD_W +: `CACHE_WORD_W] = word_at({b, 2'(k)});
        end
        return line;
    endfunction

    function automatic void write_line(
        input logic [`CACHE_BLOCK_ADDR_W-1:0] b,
        input logic [`CACHE_LINE_W-1:0]       line
    );
        for (int k = 0; k < 4; k++) begin
            words[{b, 2'(k)}] = line[k*`CACHE_WORD_W +: `CACHE_WORD_W];
        end
    endfunction

    always @(posedge clk) begin
        if (proc_reset) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            wait_cnt  <= 0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;                      // one-cycle pulse
            busy      <= 1'b0;
        end else if (busy) begin
            if (wait_cnt == 1) begin
                mem_ready <= 1'b1;
                if (mem_write) begin
                    write_line(mem_addr, mem_wdata);
                end else begin
                    mem_rdata <= read_line(mem_addr);
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_read || mem_write) begin
            busy     <= 1'b1;
            wait_cnt <= ($urandom % 4) + 1;         // 1 to 4 cycles
        end
    end

endmodule

//--- verification/cache_tb.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb;

    localparam int half_period = 4;
    localparam int wait_limit  = 40;            // edges per request

    logic                           clk;
    logic                           proc_reset;
    logic                           proc_read;
    logic                           proc_write;
    logic [`CACHE_ADDR_W-1:0]       proc_addr;
    logic [`CACHE_WORD_W-1:0]       proc_wdata;
    logic                           proc_stall;
    logic [`CACHE_WORD_W-1:0]       proc_rdata;
    logic                           mem_read;
    logic                           mem_write;
    logic [`CACHE_BLOCK_ADDR_W-1:0] mem_addr;
    logic [`CACHE_LINE_W-1:0]       mem_wdata;
    logic [`CACHE_LINE_W-1:0]       mem_rdata;
    logic                           mem_ready;

    // stimulus table, one column per queue
    string                    t_name[$];
    bit                       t_write[$];
    logic [`CACHE_ADDR_W-1:0] t_addr[$];
    logic [`CACHE_WORD_W-1:0] t_wdata[$];
    int                       t_reads[$];
    int                       t_writes[$];

    logic [`CACHE_WORD_W-1:0]       ref_words [logic [`CACHE_ADDR_W-1:0]];
    logic [`CACHE_BLOCK_ADDR_W-1:0] cur_block;
    logic [`CACHE_BLOCK_ADDR_W-1:0] addr_got;
    logic [`CACHE_LINE_W-1:0]       wdata_got;
    bit addr_bad;
    bit wdata_bad;
    int rd_count;
    int wr_count;
    int tests_run;
    int tests_failed;
    bit timed_out;

    cache_top i_dut (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    mem_model i_mem (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    always #half_period clk = ~clk;

    // completed transfers, counted where mem_ready is seen
    always @(posedge clk) begin
        if (!proc_reset && mem_ready) begin
            if (mem_read) rd_count++;
            if (mem_write) begin
                wr_count++;
                if (mem_wdata !== expected_line(cur_block)) begin
                    wdata_bad = 1'b1;
                    wdata_got = mem_wdata;
                end
            end
            if (mem_addr != cur_block) begin
                addr_bad = 1'b1;
                addr_got = mem_addr;
            end
        end
    end

    function automatic logic [`CACHE_ADDR_W-1:0] make_addr(
        input logic [`CACHE_TAG_W-1:0]    tag,
        input logic [`CACHE_INDEX_W-1:0]  index,
        input logic [`CACHE_OFFSET_W-1:0] offset
    );
        return {tag, index, offset};
    endfunction

    function automatic logic [`CACHE_WORD_W-1:0] expected_word(
        input logic [`CACHE_ADDR_W-1:0] a
    );
        if (ref_words.exists(a)) begin
            return ref_words[a];
        end
        return ({2'b00, a} * 32'd3) ^ 32'h5a5a_0000;
    endfunction

    // whole line as the reference memory holds it
    function automatic logic [`CACHE_LINE_W-1:0] expected_line(
        input logic [`CACHE_BLOCK_ADDR_W-1:0] b
    );
        logic [`CACHE_LINE_W-1:0] line;
        for (int k = 0; k < 4; k++) begin
            line[k*`CACHE_WORD_W +: `CACHE_WORD_W] = expected_word({b, 2'(k)});
        end
        return line;
    endfunction

    task automatic add_test(input string name, input bit wr, input logic [`CACHE_ADDR_W-1:0] a,
                            input logic [`CACHE_WORD_W-1:0] d, input int nr, input int nw);
        t_name.push_back(name);
        t_write.push_back(wr);
        t_addr.push_back(a);
        t_wdata.push_back(d);
        t_reads.push_back(nr);
        t_writes.push_back(nw);
    endtask

    task automatic check_reset_state();
        bit ok;
        ok = 1'b1;
        tests_run++;
        assert (!proc_stall && !mem_read && !mem_write) else begin
            $display("outputs not idle after reset: stall %b read %b write %b",
                     proc_stall, mem_read, mem_write);
            ok = 1'b0;
        end
        if (!ok) tests_failed++;
        $display("%s reset_state", ok ? "ok  " : "fail");
    endtask

    task automatic run_test(input int i);
        int                       cycles;
        int                       rd0;
        int                       wr0;
        bit                       done;
        bit                       stalled;
        bit                       ok;
        logic [`CACHE_WORD_W-1:0] got;
        logic [`CACHE_WORD_W-1:0] exp;
        cycles  = 0;
        done    = 1'b0;
        stalled = 1'b0;
        ok      = 1'b1;
        got     = '0;
        @(negedge clk);
        rd0        = rd_count;
        wr0        = wr_count;
        addr_bad   = 1'b0;
        wdata_bad  = 1'b0;
        cur_block  = t_addr[i][`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
        if (t_write[i]) begin
            ref_words[t_addr[i]] = t_wdata[i];  // write-through line carries the new word
        end
        proc_addr  = t_addr[i];
        proc_wdata = t_wdata[i];
        proc_read  = !t_write[i];
        proc_write = t_write[i];
        while (!done && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
            if (proc_stall) begin
                stalled = 1'b1;
            end else begin
                done = 1'b1;
                got  = proc_rdata;
            end
        end
        @(negedge clk);
        proc_read  = 1'b0;
        proc_write = 1'b0;
        tests_run++;
        if (!done) begin
            $display("timeout in %s: stall still high after %0d cycles", t_name[i], cycles);
            timed_out = 1'b1;
            ok        = 1'b0;
        end else begin
            if (!t_write[i]) begin
                exp = expected_word(t_addr[i]);
                assert (got === exp) else begin
                    $display("Mismatch %s: expected %h, actual %h", t_name[i], exp, got);
                    ok = 1'b0;
                end
            end
            assert (rd_count - rd0 == t_reads[i] && wr_count - wr0 == t_writes[i]) else begin
                $display("%s made %0d memory reads and %0d writes instead of %0d and %0d",
                         t_name[i], rd_count - rd0, wr_count - wr0, t_reads[i], t_writes[i]);
                ok = 1'b0;
            end
            assert (!addr_bad) else begin
                $display("Mismatch %s mem_addr: expected %h, actual %h",
                         t_name[i], cur_block, addr_got);
                ok = 1'b0;
            end
            assert (!wdata_bad) else begin
                $display("Mismatch %s mem_wdata: expected %h, actual %h",
                         t_name[i], expected_line(cur_block), wdata_got);
                ok = 1'b0;
            end
            assert (stalled == (t_reads[i] + t_writes[i] != 0)) else begin
                $display("%s: stall at a clock edge was %0s", t_name[i],
                         stalled ? "seen on a hit" : "never seen on a miss or write");
                ok = 1'b0;
            end
        end
        if (!ok) tests_failed++;
        $display("%s %s", ok ? "ok  " : "fail", t_name[i]);
    endtask

    initial begin
        void'($urandom(32'hed22_6fdf));
        clk          = 1'b0;
        proc_reset   = 1'b1;
        proc_read    = 1'b0;
        proc_write   = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        cur_block    = '0;
        addr_got     = '0;
        wdata_got    = '0;
        addr_bad     = 1'b0;
        wdata_bad    = 1'b0;
        rd_count     = 0;
        wr_count     = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        //       name                 wr    address                           data   rd wr
        add_test("rd_miss_first",     1'b0, make_addr(26'h5, 2'd1, 2'd2), 32'h0, 1, 0);
        add_test("rd_hit_same_word",  1'b0, make_addr(26'h5, 2'd1, 2'd2), 32'h0, 0, 0);
        add_test("rd_hit_word0",      1'b0, make_addr(26'h5, 2'd1, 2'd0), 32'h0, 0, 0);
        add_test("rd_hit_word3",      1'b0, make_addr(26'h5, 2'd1, 2'd3), 32'h0, 0, 0);
        add_test("wr_hit",            1'b1, make_addr(26'h5, 2'd1, 2'd1), 32'hdead_beef, 0, 1);
        add_test("rd_after_wr_hit",   1'b0, make_addr(26'h5, 2'd1, 2'd1), 32'h0, 0, 0);
        add_test("wr_miss",           1'b1, make_addr(26'h9, 2'd2, 2'd3), 32'h1234_5678, 1, 1);
        add_test("rd_after_wr_miss",  1'b0, make_addr(26'h9, 2'd2, 2'd3), 32'h0, 0, 0);
        add_test("rd_wr_miss_line",   1'b0, make_addr(26'h9, 2'd2, 2'd0), 32'h0, 0, 0);
        add_test("evict_rd_a",        1'b0, make_addr(26'h11, 2'd3, 2'd0), 32'h0, 1, 0);
        add_test("evict_rd_b",        1'b0, make_addr(26'h22, 2'd3, 2'd1), 32'h0, 1, 0);
        add_test("evict_rd_a_again",  1'b0, make_addr(26'h11, 2'd3, 2'd2), 32'h0, 0, 0);
        add_test("evict_rd_c",        1'b0, make_addr(26'h33, 2'd3, 2'd3), 32'h0, 1, 0);
        add_test("evict_hit_a",       1'b0, make_addr(26'h11, 2'd3, 2'd1), 32'h0, 0, 0);
        add_test("evict_miss_b",      1'b0, make_addr(26'h22, 2'd3, 2'd1), 32'h0, 1, 0);
        add_test("rd_high_addr",      1'b0, make_addr(26'h3ff_fffe, 2'd0, 2'd3), 32'h0, 1, 0);
        add_test("wr_high_addr",      1'b1, make_addr(26'h3ff_fffe, 2'd0, 2'd2), 32'hc0de_0042, 0, 1);
        add_test("rd_high_addr_back", 1'b0, make_addr(26'h3ff_fffe, 2'd0, 2'd2), 32'h0, 0, 0);

        repeat (5) @(posedge clk);
        @(negedge clk);
        proc_reset = 1'b0;
        check_reset_state();

        for (int i = 0; i < t_name.size(); i++) begin
            if (!timed_out) run_test(i);    // a hung DUT makes later results meaningless
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/line_datapath.sv
verilog/replace_policy.sv
verilog/way_array.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
verification/mem_model.sv
verification/cache_tb.sv

//--- Makefile
# Verilator build and run of the data cache testbench

TOP := cache_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q -F '*** PASSED ***' $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)
